//--- hw/hyper_w_pkg.sv
/* Widths, beat and descriptor structs and the converter state
   for the HyperBus write-data path. */

package hyper_w_pkg;

  localparam int unsigned NumPhys      = 2;  // 16-bit PHYs side by side.
  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned NumAxiBytes  = AxiDataWidth / 8;
  localparam int unsigned NumPhyBytes  = NumPhys * 2;
  localparam int unsigned AddrWidth    = 3;  // Byte offset in an AXI beat.
  localparam int unsigned LenWidth     = 8;

  typedef logic [AxiDataWidth-1:0]  axi_data_t;
  typedef logic [NumAxiBytes-1:0]   axi_strb_t;
  typedef logic [8*NumPhyBytes-1:0] phy_data_t;
  typedef logic [NumPhyBytes-1:0]   phy_strb_t;
  typedef logic [AddrWidth-1:0]     byte_off_t;
  typedef logic [2:0]               axi_size_t;  // Log2 of bytes per beat.
  typedef logic [LenWidth-1:0]      beat_len_t;

  typedef struct packed {
    byte_off_t start_addr;
    axi_size_t size;
    beat_len_t len;
    logic      is_write;
  } trans_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    phy_data_t data;
    phy_strb_t strb;
    logic      last;
  } phy_beat_t;

  typedef enum logic [1:0] {
    Idle,
    WaitData,
    Sample,
    SendPhy
  } w2phy_state_t;

endpackage

//--- hw/hyper_trans_gate.sv
/* Write-address gate: descriptor register and the busy control
   that allows one transaction at a time. */
`timescale 1ns/1ps

module hyper_trans_gate (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  hyper_w_pkg::trans_t aw_i,
  input  logic                burst_done_i,
  output hyper_w_pkg::trans_t trans_o,
  output logic                trans_start_o
);
  import hyper_w_pkg::*;

  typedef enum logic [1:0] {
    GateIdle,
    GateStart,
    GateBusy
  } gate_state_t;

  gate_state_t state_d, state_q;
  trans_t      trans_q;
  logic        aw_hs;

  assign aw_ready_o    = (state_q == GateIdle);
  assign aw_hs         = aw_valid_i & aw_ready_o;
  assign trans_start_o = (state_q == GateStart);
  assign trans_o       = trans_q;

  always_comb begin : gate_fsm
    state_d = state_q;
    case (state_q)
      GateIdle: begin
        if (aw_hs) begin
          state_d = GateStart;
        end
      end
      GateStart: begin
        // Reads carry no data here.
        if (trans_q.is_write) begin
          state_d = GateBusy;
        end else begin
          state_d = GateIdle;
        end
      end
      GateBusy: begin
        if (burst_done_i) begin
          state_d = GateIdle;  // Last PHY beat has left.
        end
      end
      default: begin
        state_d = GateIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= GateIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      trans_q <= aw_i;
    end
  end

endmodule

//--- hw/hyper_w2phy.sv
/* AXI write-beat to PHY-beat converter. Full and 32-bit sizes are split
   into PHY words, 8- and 16-bit sizes are packed into them. */
`timescale 1ns/1ps

module hyper_w2phy (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  hyper_w_pkg::trans_t    trans_i,
  input  logic                   trans_start_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  input  hyper_w_pkg::axi_w_t    w_i,
  output logic                   beat_valid_o,
  input  logic                   beat_ready_i,
  output hyper_w_pkg::phy_beat_t beat_o
);
  import hyper_w_pkg::*;

  w2phy_state_t state_d, state_q;
  axi_w_t       buf_d, buf_q;
  byte_off_t    byte_idx_d, byte_idx_q;  // Next lane in the AXI beat.
  byte_off_t    phy_cnt_d, phy_cnt_q;    // First lane of the word being sent.
  byte_off_t    end_cnt_d, end_cnt_q;
  phy_strb_t    mask_d, mask_q;
  logic         first_d, first_q;
  byte_off_t    byte_next;
  logic         narrow;
  logic         w_hs;
  logic         beat_hs;
  logic         word_end;

  assign narrow   = (trans_i.size < axi_size_t'($clog2(NumPhyBytes)));
  assign w_hs     = w_valid_i & w_ready_o;
  assign beat_hs  = beat_valid_o & beat_ready_i;
  assign word_end = (phy_cnt_q == end_cnt_q);

  // Aligned lane plus one beat, wraps at the AXI width.
  assign byte_next = ((byte_idx_q >> trans_i.size) << trans_i.size)
                     + byte_off_t'(1 << trans_i.size);

  assign beat_o.data = buf_q.data[8*phy_cnt_q +: 8*NumPhyBytes];
  assign beat_o.strb = buf_q.strb[phy_cnt_q +: NumPhyBytes] & mask_q;
  assign beat_o.last = buf_q.last & word_end;

  always_comb begin : counters
    byte_idx_d = byte_idx_q;
    first_d    = first_q;
    phy_cnt_d  = phy_cnt_q;
    end_cnt_d  = end_cnt_q;
    if (trans_start_i) begin
      byte_idx_d = trans_i.start_addr;
      first_d    = 1'b1;
    end
    if (w_hs) begin
      byte_idx_d = byte_next;
      first_d    = 1'b0;
      phy_cnt_d  = byte_idx_q & ~byte_off_t'(NumPhyBytes - 1);
      // Full-width beats run up to the top word.
      if (trans_i.size > axi_size_t'($clog2(NumPhyBytes))) begin
        end_cnt_d = byte_off_t'(NumAxiBytes - NumPhyBytes);
      end else begin
        end_cnt_d = phy_cnt_d;
      end
    end
    if (beat_hs && !word_end) begin
      phy_cnt_d = phy_cnt_q + byte_off_t'(NumPhyBytes);
    end
  end

  always_comb begin : sampler
    buf_d = buf_q;
    if (trans_start_i) begin
      buf_d.strb = '0;
      buf_d.last = 1'b0;
    end else if (w_hs) begin
      if (!narrow) begin
        buf_d = w_i;  // Whole beat, sent word by word.
      end else begin
        for (int b = 0; b < NumAxiBytes; b++) begin
          if ((byte_off_t'(b) >> trans_i.size) == (byte_idx_q >> trans_i.size)) begin
            buf_d.data[8*b +: 8] = w_i.data[8*b +: 8];
            buf_d.strb[b]        = w_i.strb[b];
          end
        end
        buf_d.last = w_i.last;
      end
      // No bytes below the start offset.
      if (first_q) begin
        for (int b = 0; b < NumAxiBytes; b++) begin
          if (b < byte_idx_q) begin
            buf_d.strb[b] = 1'b0;
          end
        end
      end
    end
  end

  always_comb begin : fsm
    state_d      = state_q;
    mask_d       = mask_q;
    w_ready_o    = 1'b0;
    beat_valid_o = 1'b0;
    case (state_q)
      Idle: begin
        if (trans_start_i && trans_i.is_write) begin
          state_d = WaitData;
        end
      end
      WaitData: begin
        if (w_valid_i) begin
          state_d = Sample;
        end
      end
      Sample: begin
        w_ready_o = 1'b1;
        mask_d    = '1;
        if (w_valid_i) begin
          if (!narrow || (byte_next % NumPhyBytes) == 0) begin
            state_d = SendPhy;
          end else if (w_i.last) begin
            // Short last word.
            state_d = SendPhy;
            for (int k = 0; k < NumPhyBytes; k++) begin
              mask_d[k] = (k < int'(byte_next % NumPhyBytes));
            end
          end else begin
            state_d = WaitData;
          end
        end
      end
      SendPhy: begin
        beat_valid_o = 1'b1;
        if (beat_ready_i) begin
          if (beat_o.last) begin
            state_d = Idle;
          end else if (word_end) begin
            state_d = WaitData;
          end
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      byte_idx_q <= '0;
      phy_cnt_q  <= '0;
      end_cnt_q  <= '0;
      mask_q     <= '1;
      first_q    <= 1'b0;
    end else begin
      state_q    <= state_d;
      byte_idx_q <= byte_idx_d;
      phy_cnt_q  <= phy_cnt_d;
      end_cnt_q  <= end_cnt_d;
      mask_q     <= mask_d;
      first_q    <= first_d;
    end
  end

  always_ff @(posedge clk_i) begin
    buf_q <= buf_d;
  end

endmodule

//--- hw/hyper_phy_buf.sv
/* Two-entry PHY beat FIFO with registered outputs and
   end-of-burst pulse at the PHY port. */
`timescale 1ns/1ps

module hyper_phy_buf (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   beat_valid_i,
  output logic                   beat_ready_o,
  input  hyper_w_pkg::phy_beat_t beat_i,
  output logic                   phy_valid_o,
  input  logic                   phy_ready_i,
  output hyper_w_pkg::phy_beat_t phy_o,
  output logic                   burst_done_o
);
  import hyper_w_pkg::*;

  phy_beat_t  mem_q [2];
  logic       wr_ptr_q, rd_ptr_q;
  logic [1:0] cnt_q;
  logic       push, pop;

  assign beat_ready_o = (cnt_q != 2'd2);  // Low only when full.
  assign phy_valid_o  = (cnt_q != 2'd0);
  assign phy_o        = mem_q[rd_ptr_q];
  assign push         = beat_valid_i & beat_ready_o;
  assign pop          = phy_valid_o & phy_ready_i;
  assign burst_done_o = pop & phy_o.last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= beat_i;
    end
  end

endmodule

//--- hw/hyper_w_top.sv
/* Write-data path top: address gate, beat converter
   and PHY output buffer. */
`timescale 1ns/1ps

module hyper_w_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  hyper_w_pkg::trans_t    aw_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  input  hyper_w_pkg::axi_w_t    w_i,
  output logic                   phy_valid_o,
  input  logic                   phy_ready_i,
  output hyper_w_pkg::phy_beat_t phy_o
);
  import hyper_w_pkg::*;

  trans_t    trans;
  logic      trans_start;
  logic      burst_done;
  logic      beat_valid;
  logic      beat_ready;
  phy_beat_t beat;

  hyper_trans_gate u_trans_gate (
    .clk_i,
    .rst_ni,
    .aw_valid_i,
    .aw_ready_o,
    .aw_i,
    .burst_done_i  (burst_done),
    .trans_o       (trans),
    .trans_start_o (trans_start)
  );

  hyper_w2phy u_w2phy (
    .clk_i,
    .rst_ni,
    .trans_i       (trans),
    .trans_start_i (trans_start),
    .w_valid_i,
    .w_ready_o,
    .w_i,
    .beat_valid_o  (beat_valid),
    .beat_ready_i  (beat_ready),
    .beat_o        (beat)
  );

  hyper_phy_buf u_phy_buf (
    .clk_i,
    .rst_ni,
    .beat_valid_i  (beat_valid),
    .beat_ready_o  (beat_ready),
    .beat_i        (beat),
    .phy_valid_o,
    .phy_ready_i,
    .phy_o,
    .burst_done_o  (burst_done)
  );

endmodule

//--- verification/tb_hyper_w.sv
/* Testbench for the HyperBus write-data path.
   Stimulus, scoreboard, assertion checks and watchdog. */
`timescale 1ns/1ps

module tb_hyper_w;
  import hyper_w_pkg::*;

  localparam int ClkPeriod   = 20;
  localparam int ResetCycles = 5;
  localparam int TotalBeats  = 4 + 3 + 11 + 4 + 16 + 1;  // Read counts as one.
  localparam int WatchdogCycles = 200 * TotalBeats + ResetCycles;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      aw_valid_i;
  logic      aw_ready_o;
  trans_t    aw_i;
  logic      w_valid_i;
  logic      w_ready_o;
  axi_w_t    w_i;
  logic      phy_valid_o;
  logic      phy_ready_i;
  phy_beat_t phy_o;

  integer    seed = 9875;
  int        errors = 0;
  int        n_checks = 0;
  string     test_name = "reset";
  logic      bp_mode = 1'b0;
  logic      busy = 1'b0;
  logic      release_chk = 1'b0;
  int        read_wait = 0;
  axi_w_t    w_q[$];
  phy_beat_t exp_q[$];

  hyper_w_top u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .aw_i        (aw_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .w_i         (w_i),
    .phy_valid_o (phy_valid_o),
    .phy_ready_i (phy_ready_i),
    .phy_o       (phy_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always @(negedge clk_i) begin
    if (bp_mode) begin
      phy_ready_i = 1'($random(seed));
    end else begin
      phy_ready_i = 1'b1;
    end
  end

  // Strobe, last and every enabled data byte must agree.
  function automatic logic beat_match(phy_beat_t exp_b, phy_beat_t act_b);
    logic ok;
    ok = (exp_b.strb === act_b.strb) && (exp_b.last === act_b.last);
    for (int k = 0; k < NumPhyBytes; k++) begin
      if (exp_b.strb[k] && (exp_b.data[8*k +: 8] !== act_b.data[8*k +: 8])) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // Random AXI beats and the PHY beats they must turn into.
  task automatic build_burst(input axi_size_t size, input byte_off_t off, input int nbeats);
    axi_w_t    w;
    phy_beat_t pb;
    int        addr;
    int        nb;
    int        lane;
    pb   = '0;
    nb   = 1 << size;
    addr = off;
    for (int i = 0; i < nbeats; i++) begin
      w.data = {$random(seed), $random(seed)};
      w.strb = axi_strb_t'($random(seed));
      w.last = (i == nbeats - 1);
      w_q.push_back(w);
      if (size == 3) begin
        for (int h = 0; h < 2; h++) begin
          if (addr % 8 < 4 * h + 4) begin  // Word holds addressed bytes.
            pb.data = w.data[32*h +: 32];
            pb.strb = w.strb[4*h +: 4];
            for (int k = 0; k < 4; k++) begin
              if (4 * h + k < addr % 8) begin
                pb.strb[k] = 1'b0;
              end
            end
            pb.last = w.last && (h == 1);
            exp_q.push_back(pb);
          end
        end
      end else begin
        for (int k = 0; k < nb; k++) begin
          lane = (addr + k) % 4;
          pb.data[8*lane +: 8] = w.data[8*((addr + k) % 8) +: 8];
          pb.strb[lane]        = w.strb[(addr + k) % 8];
        end
        if ((addr + nb) % 4 == 0 || w.last) begin
          pb.last = w.last;
          exp_q.push_back(pb);
          pb = '0;
        end
      end
      addr = (addr / nb) * nb + nb;  // Next aligned address.
    end
  endtask

  task automatic send_address(input byte_off_t off, input axi_size_t size,
                              input int nbeats, input logic is_write);
    @(negedge clk_i);
    aw_valid_i      = 1'b1;
    aw_i.start_addr = off;
    aw_i.size       = size;
    aw_i.len        = beat_len_t'(nbeats - 1);
    aw_i.is_write   = is_write;
    @(posedge clk_i);
    while (!aw_ready_o) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
  endtask

  task automatic run_write(input string name, input axi_size_t size, input byte_off_t off,
                           input int nbeats, input logic stall);
    int waited;
    test_name = name;
    build_burst(size, off, nbeats);
    bp_mode <= stall;
    send_address(off, size, nbeats, 1'b1);
    while (w_q.size() != 0) begin
      w_valid_i = 1'b1;
      w_i       = w_q.pop_front();
      @(posedge clk_i);
      while (!w_ready_o) begin
        @(posedge clk_i);
      end
      @(negedge clk_i);
    end
    w_valid_i = 1'b0;
    waited    = 0;
    while (exp_q.size() != 0 && waited < 200 * nbeats) begin
      @(negedge clk_i);
      waited++;
    end
    bp_mode <= 1'b0;
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%s: %0d PHY beats never arrived", test_name, exp_q.size());
    end
    exp_q.delete();
  endtask

  always @(posedge clk_i) begin : monitor
    phy_beat_t exp_b;
    if (rst_ni) begin
      if (busy) begin
        assert (!aw_ready_o) else begin
          errors++;
          $display("%s: aw_ready_o rose before the write burst ended", test_name);
        end
      end
      if (release_chk) begin
        assert (aw_ready_o) else begin
          errors++;
          $display("%s: aw_ready_o did not return after the last PHY beat", test_name);
        end
      end
      release_chk = 1'b0;
      if (read_wait == 1) begin
        assert (aw_ready_o) else begin
          errors++;
          $display("%s: aw_ready_o not back two cycles after the read", test_name);
        end
      end
      if (read_wait > 0) begin
        read_wait--;
      end
      if (aw_valid_i && aw_ready_o) begin
        busy = aw_i.is_write;
        if (!aw_i.is_write) begin
          read_wait = 2;
        end
      end
      if (phy_valid_o && phy_ready_i) begin
        n_checks++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("%s: unexpected PHY beat %h", test_name, phy_o);
        end
        if (exp_q.size() != 0) begin
          exp_b = exp_q.pop_front();
          assert (beat_match(exp_b, phy_o)) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h actual %h", test_name, exp_b, phy_o);
          end
        end
        if (phy_o.last) begin
          busy        = 1'b0;
          release_chk = 1'b1;
        end
      end
    end
  end

  initial begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog timeout: the run did not complete in time");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    rst_ni      = 1'b0;
    aw_valid_i  = 1'b0;
    aw_i        = '0;
    w_valid_i   = 1'b0;
    w_i         = '0;
    phy_ready_i = 1'b1;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (!phy_valid_o && !w_ready_o && aw_ready_o) else begin
      errors++;
      $display("Wrong handshake levels after reset");
    end

    run_write("full_aligned", 3'd3, 3'd0, 4, 1'b0);
    run_write("unaligned_start", 3'd3, 3'd5, 3, 1'b0);
    run_write("narrow_bytes", 3'd0, 3'd0, 11, 1'b0);
    run_write("narrow_halfwords", 3'd1, 3'd2, 4, 1'b0);
    run_write("back_pressure", 3'd3, 3'd3, 16, 1'b1);
    test_name = "read_descriptor";
    send_address(3'd0, 3'd3, 1, 1'b0);
    repeat (10) @(negedge clk_i);  // Room for a stray beat.

    $display("PHY beats checked: %0d, errors: %0d", n_checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- vlog.f
hw/hyper_w_pkg.sv
hw/hyper_trans_gate.sv
hw/hyper_w2phy.sv
hw/hyper_phy_buf.sv
hw/hyper_w_top.sv
verification/tb_hyper_w.sv

//--- Bender.yml
package:
  name: hyper_w

sources:
  - files:
      - hw/hyper_w_pkg.sv
      - hw/hyper_trans_gate.sv
      - hw/hyper_w2phy.sv
      - hw/hyper_phy_buf.sv
      - hw/hyper_w_top.sv
  - target: test
    files:
      - verification/tb_hyper_w.sv
